// ==== hw/ozma_pkg.sv ====
package ozma_pkg;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic coin;
		logic start1;
		logic start2;
	} cab_buttons_t;

	// bit 4 down to bit 0 of the joystick port
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic       reset_cmd;   // reset entry of the OSD menu
		logic       overlay_off;
		logic [1:0] scanlines;   // for the scan doubler downstream
		logic       rotate;
		logic       menu_reset;
	} frontend_status_t;

	// all low active except coin
	typedef struct packed {
		logic coin;
		logic sel1;
		logic sel2;
		logic fire;
		logic move_left;
		logic move_right;
		logic move_up;
		logic move_down;
	} core_ctrl_t;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb1_t;

	// PS/2 set 2 scan codes
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6b;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_ESC   = 8'h76; // coin
	localparam logic [7:0] KEY_F1    = 8'h05; // start1
	localparam logic [7:0] KEY_F2    = 8'h06; // start2
	localparam logic [7:0] KEY_SPACE = 8'h29; // fire

endpackage

// ==== hw/key_latch.sv ====
module key_latch (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    key_strobe,
	input  logic [7:0]              key_code,
	input  logic                    key_pressed,
	output ozma_pkg::cab_buttons_t  buttons
);

	import ozma_pkg::*;

	cab_buttons_t btn_q;

	// one held level per button, written only by its own code
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			btn_q <= '0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP: begin
					btn_q.up <= key_pressed;
				end
				KEY_DOWN: begin
					btn_q.down <= key_pressed;
				end
				KEY_LEFT: begin
					btn_q.left <= key_pressed;
				end
				KEY_RIGHT: begin
					btn_q.right <= key_pressed;
				end
				KEY_ESC: begin
					btn_q.coin <= key_pressed;
				end
				KEY_F1: begin
					btn_q.start1 <= key_pressed;
				end
				KEY_F2: begin
					btn_q.start2 <= key_pressed;
				end
				KEY_SPACE: begin
					btn_q.fire <= key_pressed;
				end
				default: begin
					btn_q <= btn_q; // unmapped code, nothing held
				end
			endcase
		end
	end

	assign buttons = btn_q;

endmodule

// ==== hw/control_mapper.sv ====
module control_mapper (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  ozma_pkg::cab_buttons_t      buttons,
	input  ozma_pkg::joy_t              joy_0,
	input  ozma_pkg::joy_t              joy_1,
	input  ozma_pkg::frontend_status_t  status,
	input  logic                        panel_reset,
	output ozma_pkg::core_ctrl_t        core_ctrl,
	output logic                        core_rst_n
);

	import ozma_pkg::*;

	localparam core_ctrl_t CTRL_IDLE = '{
		coin:       1'b0,
		sel1:       1'b1,
		sel2:       1'b1,
		fire:       1'b1,
		move_left:  1'b1,
		move_right: 1'b1,
		move_up:    1'b1,
		move_down:  1'b1
	};

	logic       up_any;
	logic       down_any;
	logic       left_any;
	logic       right_any;
	logic       fire_any;
	logic       m_up;
	logic       m_down;
	logic       m_left;
	logic       m_right;
	logic       rst_req;
	core_ctrl_t ctrl_next;

	// keyboard or either stick
	assign up_any    = buttons.up | joy_0.up | joy_1.up;
	assign down_any  = buttons.down | joy_0.down | joy_1.down;
	assign left_any  = buttons.left | joy_0.left | joy_1.left;
	assign right_any = buttons.right | joy_0.right | joy_1.right;
	assign fire_any  = buttons.fire | joy_0.fire | joy_1.fire;

	// cabinet monitor sits sideways, so the default turns the sticks 90 degrees
	assign m_up    = status.rotate ? up_any : right_any;
	assign m_down  = status.rotate ? down_any : left_any;
	assign m_left  = status.rotate ? left_any : up_any;
	assign m_right = status.rotate ? right_any : down_any;

	assign rst_req = status.menu_reset | status.reset_cmd | panel_reset;

	always_comb begin
		ctrl_next.coin       = buttons.coin; // core wants coin high active
		ctrl_next.sel1       = ~buttons.start1;
		ctrl_next.sel2       = ~buttons.start2;
		ctrl_next.fire       = ~fire_any;
		ctrl_next.move_left  = ~m_left;
		ctrl_next.move_right = ~m_right;
		ctrl_next.move_up    = ~m_up;
		ctrl_next.move_down  = ~m_down;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			core_ctrl  <= CTRL_IDLE;
			core_rst_n <= 1'b0;
		end else begin
			core_ctrl  <= ctrl_next;
			core_rst_n <= ~rst_req;
		end
	end

endmodule

// ==== hw/color_overlay.sv ====
module color_overlay #(
	parameter int BAND1_END = 32,
	parameter int BAND2_END = 192
) (
	input  logic             clk_sys,
	input  logic             arst_n,
	input  logic             video,
	input  logic             hsync,
	input  logic             vsync,
	input  logic             overlay_off,
	output ozma_pkg::rgb1_t  rgb,
	output logic             hs_out,
	output logic             vs_out
);

	import ozma_pkg::*;

	localparam int COL_W = $clog2(BAND2_END + 1);

	localparam rgb1_t BLACK = '{r: 1'b0, g: 1'b0, b: 1'b0};
	localparam rgb1_t WHITE = '{r: 1'b1, g: 1'b1, b: 1'b1};
	localparam rgb1_t RED   = '{r: 1'b1, g: 1'b0, b: 1'b0};
	localparam rgb1_t GREEN = '{r: 1'b0, g: 1'b1, b: 1'b0};

	logic [COL_W-1:0] col;
	logic             hs_rise;
	rgb1_t            rgb_next;

	// hs_out is last cycle's hsync, so it doubles as the edge detector
	assign hs_rise = hsync & ~hs_out;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			col <= '0;
		end else if (hs_rise) begin
			col <= '0;
		end else if (col != COL_W'(BAND2_END)) begin
			col <= col + 1'b1; // stops once into the last band
		end
	end

	// cellophane strips: red at the bottom, clear middle, green at the top
	always_comb begin
		if (!video) begin
			rgb_next = BLACK;
		end else if (overlay_off) begin
			rgb_next = WHITE;
		end else if (col < COL_W'(BAND1_END)) begin
			rgb_next = RED;
		end else if (col < COL_W'(BAND2_END)) begin
			rgb_next = WHITE;
		end else begin
			rgb_next = GREEN;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rgb    <= BLACK;
			hs_out <= 1'b0;
			vs_out <= 1'b0;
		end else begin
			rgb    <= rgb_next;
			hs_out <= hsync; // keep syncs aligned with the color
			vs_out <= vsync;
		end
	end

endmodule

// ==== hw/audio_dac.sv ====
module audio_dac #(
	parameter int DAC_BITS = 8
) (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic [DAC_BITS-1:0] audio,
	output logic                aud_bit
);

	logic [DAC_BITS:0] acc;

	// first order sigma-delta, top bit is the carry out of the add
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[DAC_BITS-1:0]} + {1'b0, audio}; // carry dropped
		end
	end

	assign aud_bit = acc[DAC_BITS];

endmodule

// ==== hw/ozma_frontend.sv ====
module ozma_frontend #(
	parameter int BAND1_END = 32,
	parameter int BAND2_END = 192,
	parameter int DAC_BITS  = 8
) (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  logic                        key_strobe,
	input  logic [7:0]                  key_code,
	input  logic                        key_pressed,
	input  ozma_pkg::joy_t              joy_0,
	input  ozma_pkg::joy_t              joy_1,
	input  ozma_pkg::frontend_status_t  status,
	input  logic                        panel_reset,
	input  logic                        video,
	input  logic                        hsync,
	input  logic                        vsync,
	input  logic [DAC_BITS-1:0]         audio,
	output ozma_pkg::core_ctrl_t        core_ctrl,
	output logic                        core_rst_n,
	output ozma_pkg::rgb1_t             rgb,
	output logic                        hs_out,
	output logic                        vs_out,
	output logic                        aud_l,
	output logic                        aud_r
);

	import ozma_pkg::*;

	cab_buttons_t buttons;

	key_latch key_latch_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.buttons     (buttons)
	);

	control_mapper control_mapper_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.buttons     (buttons),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.status      (status),
		.panel_reset (panel_reset),
		.core_ctrl   (core_ctrl),
		.core_rst_n  (core_rst_n)
	);

	color_overlay #(
		.BAND1_END (BAND1_END),
		.BAND2_END (BAND2_END)
	) color_overlay_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.video       (video),
		.hsync       (hsync),
		.vsync       (vsync),
		.overlay_off (status.overlay_off),
		.rgb         (rgb),
		.hs_out      (hs_out),
		.vs_out      (vs_out)
	);

	audio_dac #(
		.DAC_BITS (DAC_BITS)
	) audio_dac_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.audio   (audio),
		.aud_bit (aud_l)
	);

	assign aud_r = aud_l; // mono core, same stream on both channels

endmodule

// ==== verif/ozma_frontend_props.sv ====
module ozma_frontend_props (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  logic                        key_strobe,
	input  logic [7:0]                  key_code,
	input  ozma_pkg::joy_t              joy_0,
	input  ozma_pkg::joy_t              joy_1,
	input  ozma_pkg::frontend_status_t  status,
	input  logic                        hsync,
	input  ozma_pkg::core_ctrl_t        core_ctrl,
	input  ozma_pkg::rgb1_t             rgb,
	input  logic                        hs_out,
	input  logic                        aud_l,
	input  logic                        aud_r
);

	timeunit 1ns;
	timeprecision 1ps;

	import ozma_pkg::*;

	logic idle_code_q; // last strobe carried an unmapped code

	function automatic logic is_mapped(logic [7:0] code);
		return code inside {KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT,
			KEY_ESC, KEY_F1, KEY_F2, KEY_SPACE};
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			idle_code_q <= 1'b0;
		end else begin
			idle_code_q <= key_strobe && !is_mapped(key_code);
		end
	end

	stereo_same: assert property (@(posedge clk_sys) aud_r == aud_l)
		else $error("aud_r differs from aud_l");

	hs_delay: assert property (@(posedge clk_sys) disable iff (!arst_n)
		hs_out == $past(hsync))
		else $error("hs_out is not hsync delayed by one cycle");

	no_blue_tint: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rgb.b |-> (rgb.r && rgb.g))
		else $error("blue lit outside a white pixel");

	plain_white: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$past(status.overlay_off) |-> (rgb.r == rgb.g && rgb.g == rgb.b))
		else $error("tinted pixel with the overlay off");

	idle_code: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(idle_code_q && $stable(joy_0) && $stable(joy_1) && $stable(status))
		|=> $stable(core_ctrl))
		else $error("unmapped key code changed the core controls");

endmodule

// ==== verif/ozma_frontend_tb.sv ====
module ozma_frontend_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import ozma_pkg::*;

	localparam int BAND1_END = 24;
	localparam int BAND2_END = 160;
	localparam int DAC_BITS  = 8;

	localparam logic [7:0] MAPPED_KEYS [8] = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT,
		KEY_ESC, KEY_F1, KEY_F2, KEY_SPACE};

	logic                clk_sys;
	logic                arst_n;
	logic                key_strobe;
	logic [7:0]          key_code;
	logic                key_pressed;
	joy_t                joy_0;
	joy_t                joy_1;
	frontend_status_t    status;
	logic                panel_reset;
	logic                video;
	logic                hsync;
	logic                vsync;
	logic [DAC_BITS-1:0] audio;
	core_ctrl_t          core_ctrl;
	logic                core_rst_n;
	rgb1_t               rgb;
	logic                hs_out;
	logic                vs_out;
	logic                aud_l;
	logic                aud_r;

	logic [31:0] lcg_state;
	logic        check_en;
	int          ctrl_errs;
	int          rst_errs;
	int          video_errs;
	int          audio_errs;
	int          timeouts;

	cab_buttons_t m_btn;
	core_ctrl_t   exp_ctrl;
	logic         exp_rst_n;
	int           m_col;
	rgb1_t        exp_rgb;
	logic         exp_hs;
	logic         exp_vs;
	int           m_acc;
	logic         exp_aud;

	ozma_frontend #(
		.BAND1_END (BAND1_END),
		.BAND2_END (BAND2_END),
		.DAC_BITS  (DAC_BITS)
	) ozma_frontend_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.status      (status),
		.panel_reset (panel_reset),
		.video       (video),
		.hsync       (hsync),
		.vsync       (vsync),
		.audio       (audio),
		.core_ctrl   (core_ctrl),
		.core_rst_n  (core_rst_n),
		.rgb         (rgb),
		.hs_out      (hs_out),
		.vs_out      (vs_out),
		.aud_l       (aud_l),
		.aud_r       (aud_r)
	);

	bind ozma_frontend ozma_frontend_props ozma_frontend_props_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.key_strobe (key_strobe),
		.key_code   (key_code),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.status     (status),
		.hsync      (hsync),
		.core_ctrl  (core_ctrl),
		.rgb        (rgb),
		.hs_out     (hs_out),
		.aud_l      (aud_l),
		.aud_r      (aud_r)
	);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic code_is_mapped(logic [7:0] code);
		return code inside {KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT,
			KEY_ESC, KEY_F1, KEY_F2, KEY_SPACE};
	endfunction

	function automatic cab_buttons_t apply_key(cab_buttons_t b, logic [7:0] code, logic lvl);
		cab_buttons_t n;
		n = b;
		case (code)
			KEY_UP:    n.up = lvl;
			KEY_DOWN:  n.down = lvl;
			KEY_LEFT:  n.left = lvl;
			KEY_RIGHT: n.right = lvl;
			KEY_ESC:   n.coin = lvl;
			KEY_F1:    n.start1 = lvl;
			KEY_F2:    n.start2 = lvl;
			KEY_SPACE: n.fire = lvl;
			default:   n = b;
		endcase
		return n;
	endfunction

	function automatic core_ctrl_t ctrl_from(cab_buttons_t b, joy_t j0, joy_t j1, logic rot);
		logic       u;
		logic       d;
		logic       l;
		logic       r;
		core_ctrl_t c;
		u = b.up | j0.up | j1.up;
		d = b.down | j0.down | j1.down;
		l = b.left | j0.left | j1.left;
		r = b.right | j0.right | j1.right;
		c.coin = b.coin;
		c.sel1 = ~b.start1;
		c.sel2 = ~b.start2;
		c.fire = ~(b.fire | j0.fire | j1.fire);
		c.move_up    = rot ? ~u : ~r; // turned 90 degrees unless rotate
		c.move_down  = rot ? ~d : ~l;
		c.move_left  = rot ? ~l : ~u;
		c.move_right = rot ? ~r : ~d;
		return c;
	endfunction

	function automatic rgb1_t band_color(int col, logic lit, logic plain);
		if (!lit) begin
			return rgb1_t'(3'b000);
		end else if (plain || (col >= BAND1_END && col < BAND2_END)) begin
			return rgb1_t'(3'b111);
		end else if (col < BAND1_END) begin
			return rgb1_t'(3'b100);
		end
		return rgb1_t'(3'b010);
	endfunction

	// reference model, one step per clock
	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			m_btn     <= '0;
			exp_ctrl  <= core_ctrl_t'(8'h7f); // coin low, rest released
			exp_rst_n <= 1'b0;
			m_col     <= 0;
			exp_rgb   <= rgb1_t'(3'b000);
			exp_hs    <= 1'b0;
			exp_vs    <= 1'b0;
			m_acc     <= 0;
			exp_aud   <= 1'b0;
		end else begin
			exp_ctrl  <= ctrl_from(m_btn, joy_0, joy_1, status.rotate);
			m_btn     <= key_strobe ? apply_key(m_btn, key_code, key_pressed) : m_btn;
			exp_rst_n <= !(status.menu_reset || status.reset_cmd || panel_reset);
			exp_rgb   <= band_color(m_col, video, status.overlay_off);
			m_col     <= (hsync && !exp_hs) ? 0 : m_col + 1;
			exp_hs    <= hsync;
			exp_vs    <= vsync;
			m_acc     <= (m_acc + int'(audio)) % (1 << DAC_BITS);
			exp_aud   <= (m_acc + int'(audio)) >= (1 << DAC_BITS);
		end
	end

	always @(negedge clk_sys) begin
		if (check_en) begin
			assert (core_ctrl == exp_ctrl) else begin
				ctrl_errs++;
				$display("ERR %0t: core_ctrl %b, model %b", $time, core_ctrl, exp_ctrl);
			end
			assert (core_rst_n == exp_rst_n) else begin
				rst_errs++;
				$display("ERR %0t: core_rst_n %b, model %b", $time, core_rst_n, exp_rst_n);
			end
			assert (rgb == exp_rgb && hs_out == exp_hs && vs_out == exp_vs) else begin
				video_errs++;
				$display("ERR %0t: rgb %b hs %b vs %b, model rgb %b hs %b vs %b",
					$time, rgb, hs_out, vs_out, exp_rgb, exp_hs, exp_vs);
			end
			assert (aud_l == exp_aud && aud_r == aud_l) else begin
				audio_errs++;
				$display("ERR %0t: aud_l %b aud_r %b, model %b", $time, aud_l, aud_r, exp_aud);
			end
		end
	end

	task automatic check_reset_values();
		@(negedge clk_sys);
		assert (core_ctrl == core_ctrl_t'(8'h7f) && core_rst_n == 1'b0 && rgb == '0
			&& hs_out == 1'b0 && vs_out == 1'b0 && aud_l == 1'b0) else begin
			rst_errs++;
			$display("ERR %0t: reset values ctrl %b rst_n %b rgb %b hs %b vs %b aud %b",
				$time, core_ctrl, core_rst_n, rgb, hs_out, vs_out, aud_l);
		end
	endtask

	task automatic wait_core_reset_release(input int limit);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (core_rst_n !== 1'b1 && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		assert (core_rst_n === 1'b1) else begin
			timeouts++;
			$display("core reset was still held %0d cycles after its causes cleared", limit);
		end
	endtask

	task automatic strobe_keys(input int count);
		int          i;
		logic [31:0] r;
		logic [7:0]  code;
		core_ctrl_t  held;
		for (i = 0; i < count; i++) begin
			r = lcg_next();
			code = r[31] ? r[30:23] : (r[22] ? KEY_SPACE : r[21:14]);
			if (r[13]) begin
				code = MAPPED_KEYS[r[12:10]]; // every button gets its share
			end
			@(posedge clk_sys);
			key_strobe  <= 1'b1;
			key_code    <= code;
			key_pressed <= r[4];
			@(posedge clk_sys);
			key_strobe  <= 1'b0;
			@(negedge clk_sys);
			held = core_ctrl;
			@(posedge clk_sys);
			@(negedge clk_sys);
			if (!code_is_mapped(code)) begin
				assert (core_ctrl == held) else begin
					ctrl_errs++;
					$display("ERR %0t: unmapped code %h moved core_ctrl %b to %b",
						$time, code, held, core_ctrl);
				end
			end
		end
	endtask

	task automatic sweep_joysticks(input int count);
		int          i;
		logic [31:0] r;
		for (i = 0; i < count; i++) begin
			r = lcg_next();
			@(posedge clk_sys);
			joy_0 <= joy_t'(r[31:27]);
			joy_1 <= joy_t'(r[26:22]);
			if (i % 8 == 7) begin
				status.rotate <= ~status.rotate;
			end
		end
		@(posedge clk_sys);
		joy_0 <= '0;
		joy_1 <= '0;
	endtask

	task automatic pulse_resets(input int count);
		int          i;
		logic [31:0] r;
		for (i = 0; i < count; i++) begin
			r = lcg_next();
			@(posedge clk_sys);
			status.menu_reset <= r[31] & r[30];
			status.reset_cmd  <= r[29] & r[28];
			status.scanlines  <= r[25:24];
			panel_reset       <= r[27] & r[26];
		end
		@(posedge clk_sys);
		status.menu_reset <= 1'b0;
		status.reset_cmd  <= 1'b0;
		panel_reset       <= 1'b0;
		wait_core_reset_release(8);
	endtask

	task automatic send_lines(input int lines);
		int          i;
		int          c;
		int          len;
		int          sync_w;
		logic [31:0] r;
		for (i = 0; i < lines; i++) begin
			r = lcg_next();
			len = 40 + int'(r[31:24]);
			sync_w = 2 + int'(r[23:21]);
			for (c = 0; c < len; c++) begin
				r = lcg_next();
				@(posedge clk_sys);
				video <= r[31];
				hsync <= (c < sync_w);
				vsync <= (i % 8 == 0); // first line of each frame
				status.overlay_off <= ((i % 4) >= 2);
			end
		end
		@(posedge clk_sys);
		video <= 1'b0;
		hsync <= 1'b0;
		vsync <= 1'b0;
	endtask

	task automatic hold_audio(input int count);
		int          k;
		int          n;
		int          s;
		int          ones;
		logic [31:0] r;
		for (k = 0; k < count; k++) begin
			r = lcg_next();
			s = (k == 0) ? 0 : ((k == 1) ? 255 : int'(r[31:24]));
			@(posedge clk_sys);
			audio <= s[DAC_BITS-1:0];
			ones = 0;
			for (n = 0; n < 256; n++) begin
				@(posedge clk_sys);
				@(negedge clk_sys);
				ones += int'(aud_l);
			end
			assert (ones >= s - 1 && ones <= s + 1) else begin
				audio_errs++;
				$display("ERR %0t: sample %0d gave %0d ones in 256 cycles", $time, s, ones);
			end
		end
	endtask

	initial begin
		lcg_state   = 32'h034c6f8c;
		clk_sys     = 1'b0;
		arst_n      = 1'b0;
		key_strobe  = 1'b0;
		key_code    = '0;
		key_pressed = 1'b0;
		joy_0       = '0;
		joy_1       = '0;
		status      = '0;
		panel_reset = 1'b0;
		video       = 1'b0;
		hsync       = 1'b0;
		vsync       = 1'b0;
		audio       = '0;
		check_en    = 1'b0;
		ctrl_errs   = 0;
		rst_errs    = 0;
		video_errs  = 0;
		audio_errs  = 0;
		timeouts    = 0;
		repeat (15) @(posedge clk_sys);
		check_reset_values();
		@(posedge clk_sys);
		arst_n   <= 1'b1;
		check_en <= 1'b1;
		wait_core_reset_release(8);
		@(posedge clk_sys);
		status.rotate <= lcg_state[31];
		strobe_keys(200);
		sweep_joysticks(200);
		pulse_resets(150);
		send_lines(24);
		hold_audio(12);
		repeat (4) @(posedge clk_sys);
		$display("errors: ctrl %0d, reset %0d, video %0d, audio %0d, timeouts %0d",
			ctrl_errs, rst_errs, video_errs, audio_errs, timeouts);
		if (ctrl_errs + rst_errs + video_errs + audio_errs + timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== ozma_frontend.f ====
hw/ozma_pkg.sv
hw/key_latch.sv
hw/control_mapper.sv
hw/color_overlay.sv
hw/audio_dac.sv
hw/ozma_frontend.sv
verif/ozma_frontend_props.sv
verif/ozma_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module ozma_frontend_tb -Mdir obj_dir -f ozma_frontend.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vozma_frontend_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	echo "failure reported in $LOG"
	exit 1
fi

echo "no failure reported in $LOG"
exit 0
